/* hw/la_id_pkg.sv */
// shared widths, opcodes and decode types for the id stage
// opcodes follow the LoongArch32 reduced encoding, only the kept subset
// the instruction union has one view per major opcode format

package la_id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]   word_t;

    localparam reg_addr_t LINK_REG = 5'd1;   // bl destination

    typedef enum logic [2:0] {
        ALUSEL_NOP = 3'd0, ALUSEL_LOGIC, ALUSEL_ARITH, ALUSEL_SHIFT, ALUSEL_BRANCH
    } alusel_t;

    typedef enum logic [5:0] {
        ALUOP_NOP = 6'd0,
        ALUOP_ORI, ALUOP_ANDI, ALUOP_XORI, ALUOP_ADDI_W, ALUOP_SLTI, ALUOP_SLTUI,
        ALUOP_SLLI_W, ALUOP_SRLI_W, ALUOP_SRAI_W, ALUOP_LU12I_W,
        ALUOP_AND, ALUOP_OR, ALUOP_NOR, ALUOP_XOR, ALUOP_ADD_W, ALUOP_SUB_W,
        ALUOP_SLT, ALUOP_SLTU, ALUOP_SLL_W, ALUOP_SRL_W, ALUOP_SRA_W,
        ALUOP_B, ALUOP_BL, ALUOP_JIRL, ALUOP_BEQ, ALUOP_BNE, ALUOP_BLT, ALUOP_BGE,
        ALUOP_BLTU, ALUOP_BGEU
    } aluop_t;

    ////////////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [16:0] opcode;
        reg_addr_t   rk;       // ui5 for immediate shifts
        reg_addr_t   rj;
        reg_addr_t   rd;
    } inst_r3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } inst_ri12_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        reg_addr_t   rj;       // offs26 high bits for b/bl
        reg_addr_t   rd;
    } inst_ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        reg_addr_t   rd;
    } inst_ri20_t;

    typedef union packed {
        inst_r3_t   r3;
        inst_ri12_t ri12;
        inst_ri16_t ri16;
        inst_ri20_t ri20;
    } inst_t;

    // 3-register and immediate shift ops, bits 31:15
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W  = 17'h0002e;
    localparam logic [16:0] OPC_SRL_W  = 17'h0002f;
    localparam logic [16:0] OPC_SRA_W  = 17'h00030;
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;

    // 12-bit immediate ops, bits 31:22
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_SLTUI  = 10'h009;
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;
    localparam logic [9:0] OPC_XORI   = 10'h00f;

    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    // branches and jumps, bits 31:26
    localparam logic [5:0] OPC_JIRL = 6'h13;
    localparam logic [5:0] OPC_B    = 6'h14;
    localparam logic [5:0] OPC_BL   = 6'h15;
    localparam logic [5:0] OPC_BEQ  = 6'h16;
    localparam logic [5:0] OPC_BNE  = 6'h17;
    localparam logic [5:0] OPC_BLT  = 6'h18;
    localparam logic [5:0] OPC_BGE  = 6'h19;
    localparam logic [5:0] OPC_BLTU = 6'h1a;
    localparam logic [5:0] OPC_BGEU = 6'h1b;

endpackage

/* hw/regfile.sv */
// 32 x 32 register file, two combinational reads, one write port
// no write-through: a write lands after the edge and is seen next cycle
// r0 is cleared by reset and writes to it are dropped

module regfile (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                we_i,
    input  la_id_pkg::reg_addr_t waddr_i,
    input  la_id_pkg::word_t    wdata_i,
    input  la_id_pkg::reg_addr_t raddr1_i,
    input  la_id_pkg::reg_addr_t raddr2_i,
    output la_id_pkg::word_t    rdata1_o,
    output la_id_pkg::word_t    rdata2_o
);
    import la_id_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    // r0 stays zero even right after a write aimed at it
    a_r0_zero1: assert property (@(posedge clk) disable iff (reset_i)
        raddr1_i == '0 |-> rdata1_o == '0);
    a_r0_zero2: assert property (@(posedge clk) disable iff (reset_i)
        raddr2_i == '0 |-> rdata2_o == '0);

endmodule

/* hw/inst_decoder.sv */
// combinational decode of one instruction word
// the format view is chosen by the major opcode, branches first
// unknown words come out as ALUOP_NOP with illegal set and no write

module inst_decoder (
    input  la_id_pkg::inst_t     inst_i,
    output la_id_pkg::reg_addr_t raddr1_o,
    output la_id_pkg::reg_addr_t raddr2_o,
    output logic                 re1_o,
    output logic                 re2_o,
    output logic                 use_imm_o,
    output la_id_pkg::word_t     imm_o,
    output la_id_pkg::reg_addr_t waddr_o,
    output logic                 we_o,
    output la_id_pkg::alusel_t   alusel_o,
    output la_id_pkg::aluop_t    aluop_o,
    output logic                 illegal_o
);
    import la_id_pkg::*;

    word_t imm_si12, imm_ui12, imm_off16, imm_off26;

    assign imm_si12  = {{20{inst_i.ri12.imm12[11]}}, inst_i.ri12.imm12};
    assign imm_ui12  = {20'b0, inst_i.ri12.imm12};
    assign imm_off16 = {{14{inst_i.ri16.offs16[15]}}, inst_i.ri16.offs16, 2'b00};
    assign imm_off26 = {{4{inst_i.ri16.rj[4]}}, inst_i.ri16.rj, inst_i.ri16.rd,
                        inst_i.ri16.offs16, 2'b00};   // offs26 = {rj, rd, offs16}

    ////////////////////////////////////////////////////////////
    // opcode -> operation
    ////////////////////////////////////////////////////////////
    always_comb begin
        aluop_o = ALUOP_NOP;
        case (inst_i.ri16.opcode)
            OPC_JIRL: aluop_o = ALUOP_JIRL;
            OPC_B:    aluop_o = ALUOP_B;
            OPC_BL:   aluop_o = ALUOP_BL;
            OPC_BEQ:  aluop_o = ALUOP_BEQ;
            OPC_BNE:  aluop_o = ALUOP_BNE;
            OPC_BLT:  aluop_o = ALUOP_BLT;
            OPC_BGE:  aluop_o = ALUOP_BGE;
            OPC_BLTU: aluop_o = ALUOP_BLTU;
            OPC_BGEU: aluop_o = ALUOP_BGEU;
            default:  ;
        endcase
        if (aluop_o == ALUOP_NOP && inst_i.ri20.opcode == OPC_LU12I_W) begin
            aluop_o = ALUOP_LU12I_W;
        end
        if (aluop_o == ALUOP_NOP) begin
            case (inst_i.ri12.opcode)
                OPC_ORI:    aluop_o = ALUOP_ORI;
                OPC_ANDI:   aluop_o = ALUOP_ANDI;
                OPC_XORI:   aluop_o = ALUOP_XORI;
                OPC_ADDI_W: aluop_o = ALUOP_ADDI_W;
                OPC_SLTI:   aluop_o = ALUOP_SLTI;
                OPC_SLTUI:  aluop_o = ALUOP_SLTUI;
                default:    ;
            endcase
        end
        if (aluop_o == ALUOP_NOP) begin
            case (inst_i.r3.opcode)
                OPC_AND:    aluop_o = ALUOP_AND;
                OPC_OR:     aluop_o = ALUOP_OR;
                OPC_NOR:    aluop_o = ALUOP_NOR;
                OPC_XOR:    aluop_o = ALUOP_XOR;
                OPC_ADD_W:  aluop_o = ALUOP_ADD_W;
                OPC_SUB_W:  aluop_o = ALUOP_SUB_W;
                OPC_SLT:    aluop_o = ALUOP_SLT;
                OPC_SLTU:   aluop_o = ALUOP_SLTU;
                OPC_SLL_W:  aluop_o = ALUOP_SLL_W;
                OPC_SRL_W:  aluop_o = ALUOP_SRL_W;
                OPC_SRA_W:  aluop_o = ALUOP_SRA_W;
                OPC_SLLI_W: aluop_o = ALUOP_SLLI_W;
                OPC_SRLI_W: aluop_o = ALUOP_SRLI_W;
                OPC_SRAI_W: aluop_o = ALUOP_SRAI_W;
                default:    ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // operation -> operands, immediate, destination
    ////////////////////////////////////////////////////////////
    always_comb begin
        raddr1_o  = inst_i.r3.rj;
        raddr2_o  = inst_i.r3.rk;
        re1_o     = 1'b0;
        re2_o     = 1'b0;
        use_imm_o = 1'b0;
        imm_o     = '0;
        waddr_o   = inst_i.r3.rd;
        we_o      = 1'b0;
        alusel_o  = ALUSEL_NOP;
        illegal_o = (aluop_o == ALUOP_NOP);
        case (aluop_o)
            ALUOP_ORI, ALUOP_ANDI, ALUOP_XORI: begin
                {re1_o, use_imm_o, we_o} = 3'b111;
                imm_o    = imm_ui12;
                alusel_o = ALUSEL_LOGIC;
            end
            ALUOP_ADDI_W, ALUOP_SLTI, ALUOP_SLTUI: begin
                {re1_o, use_imm_o, we_o} = 3'b111;
                imm_o    = imm_si12;
                alusel_o = ALUSEL_ARITH;
            end
            ALUOP_SLLI_W, ALUOP_SRLI_W, ALUOP_SRAI_W: begin
                {re1_o, use_imm_o, we_o} = 3'b111;
                imm_o    = {27'b0, inst_i.r3.rk};   // ui5
                alusel_o = ALUSEL_SHIFT;
            end
            ALUOP_LU12I_W: begin
                {re1_o, use_imm_o, we_o} = 3'b111;
                raddr1_o = '0;                      // A = 0, B = si20 << 12
                imm_o    = {inst_i.ri20.si20, 12'b0};
                alusel_o = ALUSEL_LOGIC;
            end
            ALUOP_AND, ALUOP_OR, ALUOP_NOR, ALUOP_XOR: begin
                {re1_o, re2_o, we_o} = 3'b111;
                alusel_o = ALUSEL_LOGIC;
            end
            ALUOP_ADD_W, ALUOP_SUB_W, ALUOP_SLT, ALUOP_SLTU: begin
                {re1_o, re2_o, we_o} = 3'b111;
                alusel_o = ALUSEL_ARITH;
            end
            ALUOP_SLL_W, ALUOP_SRL_W, ALUOP_SRA_W: begin
                {re1_o, re2_o, we_o} = 3'b111;
                alusel_o = ALUSEL_SHIFT;
            end
            ALUOP_B, ALUOP_BL: begin
                use_imm_o = 1'b1;
                imm_o     = imm_off26;
                we_o      = (aluop_o == ALUOP_BL);
                waddr_o   = LINK_REG;
                alusel_o  = ALUSEL_BRANCH;
            end
            default: begin                          // jirl and conditional branches
                re1_o    = ~illegal_o;
                re2_o    = ~illegal_o;
                raddr2_o = inst_i.ri16.rd;
                imm_o    = imm_off16;
                we_o     = (aluop_o == ALUOP_JIRL);
                alusel_o = illegal_o ? ALUSEL_NOP : ALUSEL_BRANCH;
            end
        endcase
        if (!we_o) begin
            waddr_o = '0;
        end
    end

    // an undecodable word must never reach writeback
    a_illegal_no_we: assert final (!(illegal_o && we_o));

endmodule

/* hw/operand_bypass.sv */
// operand select with forwarding from ex (first) and mem (second)
// r0 is never forwarded; a disabled read yields zero on A
// B carries the immediate whenever use_imm_i is set

module operand_bypass (
    input  logic                 re1_i,
    input  logic                 re2_i,
    input  la_id_pkg::reg_addr_t raddr1_i,
    input  la_id_pkg::reg_addr_t raddr2_i,
    input  la_id_pkg::word_t     rdata1_i,
    input  la_id_pkg::word_t     rdata2_i,
    input  logic                 use_imm_i,
    input  la_id_pkg::word_t     imm_i,
    input  logic                 ex_we_i,
    input  la_id_pkg::reg_addr_t ex_waddr_i,
    input  la_id_pkg::word_t     ex_wdata_i,
    input  logic                 mem_we_i,
    input  la_id_pkg::reg_addr_t mem_waddr_i,
    input  la_id_pkg::word_t     mem_wdata_i,
    output la_id_pkg::word_t     opa_o,
    output la_id_pkg::word_t     opb_o
);
    import la_id_pkg::*;

    function automatic word_t pick(input logic re, input reg_addr_t addr, input word_t file_val);
        if (!re) begin
            return '0;
        end else if (addr == '0) begin
            return '0;                              // r0 is always zero
        end else if (ex_we_i && ex_waddr_i == addr) begin
            return ex_wdata_i;
        end else if (mem_we_i && mem_waddr_i == addr) begin
            return mem_wdata_i;
        end
        return file_val;
    endfunction

    always_comb begin
        opa_o = pick(re1_i, raddr1_i, rdata1_i);
        opb_o = use_imm_i ? imm_i : pick(re2_i, raddr2_i, rdata2_i);
    end

endmodule

/* hw/branch_unit.sv */
// same-cycle branch resolution on the forwarded operands
// target is pc + imm, or A + imm for jirl; imm is already shifted
// taken is forced low for an invalid slot or a non-branch

module branch_unit (
    input  logic                valid_i,
    input  la_id_pkg::word_t    pc_i,
    input  la_id_pkg::aluop_t   aluop_i,
    input  la_id_pkg::word_t    opa_i,
    input  la_id_pkg::word_t    opb_i,
    input  la_id_pkg::word_t    imm_i,
    output logic                taken_o,
    output la_id_pkg::word_t    target_o,
    output la_id_pkg::word_t    link_addr_o
);
    import la_id_pkg::*;

    logic  cond;
    logic  is_link;
    word_t base;

    always_comb begin
        case (aluop_i)
            ALUOP_B, ALUOP_BL, ALUOP_JIRL: cond = 1'b1;
            ALUOP_BEQ:  cond = (opa_i == opb_i);
            ALUOP_BNE:  cond = (opa_i != opb_i);
            ALUOP_BLT:  cond = ($signed(opa_i) <  $signed(opb_i));
            ALUOP_BGE:  cond = ($signed(opa_i) >= $signed(opb_i));
            ALUOP_BLTU: cond = (opa_i <  opb_i);
            ALUOP_BGEU: cond = (opa_i >= opb_i);
            default:    cond = 1'b0;
        endcase
    end

    assign is_link = (aluop_i == ALUOP_BL) || (aluop_i == ALUOP_JIRL);
    assign base    = (aluop_i == ALUOP_JIRL) ? opa_i : pc_i;

    assign taken_o     = valid_i & cond;
    assign target_o    = base + imm_i;
    assign link_addr_o = is_link ? pc_i + 32'd4 : '0;   // return address

endmodule

/* hw/id_ex_reg.sv */
// id/ex pipeline register, one cycle
// an invalid slot loads a bubble: valid, we and illegal low, NOP op
// operand and address payload carries no reset

module id_ex_reg (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  la_id_pkg::alusel_t   alusel_i,
    input  la_id_pkg::aluop_t    aluop_i,
    input  la_id_pkg::word_t     opa_i,
    input  la_id_pkg::word_t     opb_i,
    input  la_id_pkg::reg_addr_t waddr_i,
    input  logic                 we_i,
    input  la_id_pkg::word_t     link_addr_i,
    input  logic                 illegal_i,
    output logic                 valid_o,
    output la_id_pkg::alusel_t   alusel_o,
    output la_id_pkg::aluop_t    aluop_o,
    output la_id_pkg::word_t     opa_o,
    output la_id_pkg::word_t     opb_o,
    output la_id_pkg::reg_addr_t waddr_o,
    output logic                 we_o,
    output la_id_pkg::word_t     link_addr_o,
    output logic                 illegal_o
);
    import la_id_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i || !valid_i) begin          // reset or bubble
            valid_o   <= 1'b0;
            we_o      <= 1'b0;
            illegal_o <= 1'b0;
            alusel_o  <= ALUSEL_NOP;
            aluop_o   <= ALUOP_NOP;
        end else begin
            valid_o   <= 1'b1;
            we_o      <= we_i;
            illegal_o <= illegal_i;
            alusel_o  <= alusel_i;
            aluop_o   <= aluop_i;
        end
    end

    always_ff @(posedge clk) begin
        opa_o       <= opa_i;
        opb_o       <= opb_i;
        waddr_o     <= waddr_i;
        link_addr_o <= link_addr_i;
    end

    // a write toward execute always belongs to a real instruction
    a_we_valid: assert property (@(posedge clk) disable iff (reset_i) we_o |-> valid_o);

endmodule

/* hw/id_stage.sv */
// decode stage top: regfile read, forwarding, branch resolve, id/ex reg
// no handshake; valid_i qualifies the slot and a new one may come every cycle
// branch outputs are combinational, ex_ outputs one cycle later

module id_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  la_id_pkg::word_t     pc_i,
    input  la_id_pkg::inst_t     inst_i,
    input  logic                 ex_we_i,
    input  la_id_pkg::reg_addr_t ex_waddr_i,
    input  la_id_pkg::word_t     ex_wdata_i,
    input  logic                 mem_we_i,
    input  la_id_pkg::reg_addr_t mem_waddr_i,
    input  la_id_pkg::word_t     mem_wdata_i,
    input  logic                 wb_we_i,
    input  la_id_pkg::reg_addr_t wb_waddr_i,
    input  la_id_pkg::word_t     wb_wdata_i,
    output logic                 ex_valid_o,
    output la_id_pkg::alusel_t   ex_alusel_o,
    output la_id_pkg::aluop_t    ex_aluop_o,
    output la_id_pkg::word_t     ex_opa_o,
    output la_id_pkg::word_t     ex_opb_o,
    output la_id_pkg::reg_addr_t ex_waddr_o,
    output logic                 ex_we_o,
    output la_id_pkg::word_t     ex_link_addr_o,
    output logic                 ex_illegal_o,
    output logic                 branch_taken_o,
    output la_id_pkg::word_t     branch_target_o
);
    import la_id_pkg::*;

    reg_addr_t raddr1, raddr2, waddr;
    logic      re1, re2, use_imm, we, illegal;
    word_t     rdata1, rdata2, imm, opa, opb, link_addr;
    alusel_t   alusel;
    aluop_t    aluop;

    regfile u_regfile (
        .clk(clk), .reset_i(reset_i),
        .we_i(wb_we_i), .waddr_i(wb_waddr_i), .wdata_i(wb_wdata_i),
        .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2)
    );

    inst_decoder u_decoder (
        .inst_i(inst_i),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .re1_o(re1), .re2_o(re2),
        .use_imm_o(use_imm), .imm_o(imm), .waddr_o(waddr), .we_o(we),
        .alusel_o(alusel), .aluop_o(aluop), .illegal_o(illegal)
    );

    operand_bypass u_bypass (
        .re1_i(re1), .re2_i(re2), .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_i(rdata1), .rdata2_i(rdata2), .use_imm_i(use_imm), .imm_i(imm),
        .ex_we_i(ex_we_i), .ex_waddr_i(ex_waddr_i), .ex_wdata_i(ex_wdata_i),
        .mem_we_i(mem_we_i), .mem_waddr_i(mem_waddr_i), .mem_wdata_i(mem_wdata_i),
        .opa_o(opa), .opb_o(opb)
    );

    branch_unit u_branch (
        .valid_i(valid_i), .pc_i(pc_i), .aluop_i(aluop),
        .opa_i(opa), .opb_i(opb), .imm_i(imm),
        .taken_o(branch_taken_o), .target_o(branch_target_o), .link_addr_o(link_addr)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .reset_i(reset_i), .valid_i(valid_i),
        .alusel_i(alusel), .aluop_i(aluop), .opa_i(opa), .opb_i(opb),
        .waddr_i(waddr), .we_i(we), .link_addr_i(link_addr), .illegal_i(illegal),
        .valid_o(ex_valid_o), .alusel_o(ex_alusel_o), .aluop_o(ex_aluop_o),
        .opa_o(ex_opa_o), .opb_o(ex_opb_o), .waddr_o(ex_waddr_o), .we_o(ex_we_o),
        .link_addr_o(ex_link_addr_o), .illegal_o(ex_illegal_o)
    );

endmodule

/* test/tb_vectors.svh */
// table for tb_id_stage, one add_row call per clock cycle
// each row gives the wb write, the ex and mem forwards, valid, pc and word,
// then the expected taken, target, aluop, alusel, opa, opb, waddr, we, link, illegal
// r2 = 0x10 and r3 = -16 and r4 = 0x12345678 once loaded, all others stay 0

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic fill_table();
    // bubbles that load the register file
    add_row(wr(5'd2, 32'h10), NO_WR, NO_WR, 1'b0, 32'h0, 32'h0,
        1'b0, 32'h0, ALUOP_NOP, ALUSEL_NOP, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(wr(5'd3, 32'hfffffff0), NO_WR, NO_WR, 1'b0, 32'h0, 32'h0,
        1'b0, 32'h0, ALUOP_NOP, ALUSEL_NOP, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(wr(5'd4, 32'h12345678), NO_WR, NO_WR, 1'b0, 32'h0, 32'h0,
        1'b0, 32'h0, ALUOP_NOP, ALUSEL_NOP, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);

    // immediate forms
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h100, enc_ri12(OPC_ORI, 12'hf00, 5'd2, 5'd6),
        1'b0, 32'h0, ALUOP_ORI, ALUSEL_LOGIC, 32'h10, 32'hf00, 5'd6, 1'b1, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h104, enc_ri12(OPC_ADDI_W, 12'hff8, 5'd3, 5'd7),
        1'b0, 32'h0, ALUOP_ADDI_W, ALUSEL_ARITH, 32'hfffffff0, 32'hfffffff8, 5'd7, 1'b1,
        32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h108, enc_ri20(OPC_LU12I_W, 20'h80001, 5'd8),
        1'b0, 32'h0, ALUOP_LU12I_W, ALUSEL_LOGIC, 32'h0, 32'h80001000, 5'd8, 1'b1,
        32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h10c, enc_r3(OPC_SLLI_W, 5'd7, 5'd4, 5'd9),
        1'b0, 32'h0, ALUOP_SLLI_W, ALUSEL_SHIFT, 32'h12345678, 32'h7, 5'd9, 1'b1,
        32'h0, 1'b0);

    // forwarding: ex over mem, mem over file, never into r0
    add_row(NO_WR, wr(5'd2, 32'haaaa0000), wr(5'd2, 32'hbbbb0000), 1'b1, 32'h110,
        enc_r3(OPC_ADD_W, 5'd3, 5'd2, 5'd10), 1'b0, 32'h0, ALUOP_ADD_W, ALUSEL_ARITH,
        32'haaaa0000, 32'hfffffff0, 5'd10, 1'b1, 32'h0, 1'b0);
    add_row(NO_WR, wr(5'd5, 32'h55555555), wr(5'd4, 32'hcccc0001), 1'b1, 32'h114,
        enc_r3(OPC_SUB_W, 5'd4, 5'd3, 5'd11), 1'b0, 32'h0, ALUOP_SUB_W, ALUSEL_ARITH,
        32'hfffffff0, 32'hcccc0001, 5'd11, 1'b1, 32'h0, 1'b0);
    add_row(NO_WR, wr(5'd0, 32'h5555), wr(5'd0, 32'h6666), 1'b1, 32'h118,
        enc_r3(OPC_OR, 5'd2, 5'd0, 5'd12), 1'b0, 32'h0, ALUOP_OR, ALUSEL_LOGIC,
        32'h0, 32'h10, 5'd12, 1'b1, 32'h0, 1'b0);

    // conditional branches with A = -16 and B = 16
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1000, enc_ri16(OPC_BEQ, 16'h0010, 5'd3, 5'd2),
        1'b0, 32'h1040, ALUOP_BEQ, ALUSEL_BRANCH, 32'hfffffff0, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1100, enc_ri16(OPC_BNE, 16'hfffc, 5'd3, 5'd2),
        1'b1, 32'h10f0, ALUOP_BNE, ALUSEL_BRANCH, 32'hfffffff0, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1200, enc_ri16(OPC_BLT, 16'h0010, 5'd3, 5'd2),
        1'b1, 32'h1240, ALUOP_BLT, ALUSEL_BRANCH, 32'hfffffff0, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1300, enc_ri16(OPC_BGE, 16'h0010, 5'd3, 5'd2),
        1'b0, 32'h1340, ALUOP_BGE, ALUSEL_BRANCH, 32'hfffffff0, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1400, enc_ri16(OPC_BLTU, 16'h0010, 5'd3, 5'd2),
        1'b0, 32'h1440, ALUOP_BLTU, ALUSEL_BRANCH, 32'hfffffff0, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1500, enc_ri16(OPC_BGEU, 16'h0010, 5'd3, 5'd2),
        1'b1, 32'h1540, ALUOP_BGEU, ALUSEL_BRANCH, 32'hfffffff0, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h1600, enc_ri16(OPC_BEQ, 16'h0010, 5'd2, 5'd2),
        1'b1, 32'h1640, ALUOP_BEQ, ALUSEL_BRANCH, 32'h10, 32'h10, 5'd0, 1'b0, 32'h0, 1'b0);

    // jumps
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h2000, enc_off26(OPC_B, 26'h0000100),
        1'b1, 32'h2400, ALUOP_B, ALUSEL_BRANCH, 32'h0, 32'h400, 5'd0, 1'b0, 32'h0, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h3000, enc_off26(OPC_BL, 26'h3fffff0),
        1'b1, 32'h2fc0, ALUOP_BL, ALUSEL_BRANCH, 32'h0, 32'hffffffc0, 5'd1, 1'b1,
        32'h3004, 1'b0);
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h4000, enc_ri16(OPC_JIRL, 16'h0004, 5'd4, 5'd13),
        1'b1, 32'h12345688, ALUOP_JIRL, ALUSEL_BRANCH, 32'h12345678, 32'h0, 5'd13, 1'b1,
        32'h4004, 1'b0);

    // undefined word, then the same word in an empty slot
    add_row(NO_WR, NO_WR, NO_WR, 1'b1, 32'h5000, 32'hffffffff,
        1'b0, 32'h0, ALUOP_NOP, ALUSEL_NOP, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b1);
    add_row(NO_WR, NO_WR, NO_WR, 1'b0, 32'h5004, 32'hffffffff,
        1'b0, 32'h0, ALUOP_NOP, ALUSEL_NOP, 32'h0, 32'h0, 5'd0, 1'b0, 32'h0, 1'b0);
endtask

`endif

/* test/tb_id_stage.sv */
// testbench for id_stage, driven row by row from tb_vectors.svh
// inputs change on the falling edge, branch outputs are sampled 1 ns before
// the rising edge and the ex_ bundle 1 ns after it
// regfile has no write-through, so a wb write in one row is read in a later row
// payload fields are only compared for valid, decodable rows

module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import la_id_pkg::*;

    localparam int CLK_PERIOD = 40;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } port_t;

    typedef struct packed {
        port_t     wb;
        port_t     ex;
        port_t     mem;
        logic      valid;
        word_t     pc;
        word_t     inst;
        logic      taken;       // expected values from here on
        word_t     target;
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     opa;
        word_t     opb;
        reg_addr_t waddr;
        logic      we;
        word_t     link;
        logic      illegal;
    } row_t;

    localparam port_t NO_WR = '0;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      valid_i;
    word_t     pc_i;
    inst_t     inst_i;
    logic      ex_we_i, mem_we_i, wb_we_i;
    reg_addr_t ex_waddr_i, mem_waddr_i, wb_waddr_i;
    word_t     ex_wdata_i, mem_wdata_i, wb_wdata_i;
    logic      ex_valid_o, ex_we_o, ex_illegal_o, branch_taken_o;
    alusel_t   ex_alusel_o;
    aluop_t    ex_aluop_o;
    word_t     ex_opa_o, ex_opb_o, ex_link_addr_o, branch_target_o;
    reg_addr_t ex_waddr_o;

    row_t vecs [$];
    logic table_loaded = 1'b0;
    int   errors = 0;
    int   cur_row = -1;         // -1 while checking reset

    id_stage dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // instruction encoders and table helpers
    ////////////////////////////////////////////////////////////
    function automatic word_t enc_r3(input logic [16:0] opc, input reg_addr_t rk,
                                     input reg_addr_t rj, input reg_addr_t rd);
        return {opc, rk, rj, rd};
    endfunction

    function automatic word_t enc_ri12(input logic [9:0] opc, input logic [11:0] imm,
                                       input reg_addr_t rj, input reg_addr_t rd);
        return {opc, imm, rj, rd};
    endfunction

    function automatic word_t enc_ri16(input logic [5:0] opc, input logic [15:0] offs,
                                       input reg_addr_t rj, input reg_addr_t rd);
        return {opc, offs, rj, rd};
    endfunction

    function automatic word_t enc_ri20(input logic [6:0] opc, input logic [19:0] si20,
                                       input reg_addr_t rd);
        return {opc, si20, rd};
    endfunction

    // offs26 low half sits in 25:10, high bits in 9:0
    function automatic word_t enc_off26(input logic [5:0] opc, input logic [25:0] offs);
        return {opc, offs[15:0], offs[25:16]};
    endfunction

    function automatic port_t wr(input reg_addr_t addr, input word_t data);
        return {1'b1, addr, data};
    endfunction

    task automatic add_row(input port_t wb, input port_t ex, input port_t mem,
                           input logic valid, input word_t pc, input word_t inst,
                           input logic taken, input word_t target, input aluop_t aluop,
                           input alusel_t alusel, input word_t opa, input word_t opb,
                           input reg_addr_t waddr, input logic we, input word_t link,
                           input logic illegal);
        vecs.push_back({wb, ex, mem, valid, pc, inst, taken, target, aluop, alusel,
                        opa, opb, waddr, we, link, illegal});
    endtask

    `include "tb_vectors.svh"

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d %s got %h expected %h",
                     $time, cur_row, what, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic drive_row(input row_t r);
        wb_we_i     = r.wb.we;
        wb_waddr_i  = r.wb.addr;
        wb_wdata_i  = r.wb.data;
        ex_we_i     = r.ex.we;
        ex_waddr_i  = r.ex.addr;
        ex_wdata_i  = r.ex.data;
        mem_we_i    = r.mem.we;
        mem_waddr_i = r.mem.addr;
        mem_wdata_i = r.mem.data;
        valid_i     = r.valid;
        pc_i        = r.pc;
        inst_i      = r.inst;
    endtask

    task automatic check_branch(input row_t r);
        check(32'(branch_taken_o), 32'(r.taken), "branch_taken_o");
        if (r.valid && r.alusel == ALUSEL_BRANCH) begin
            check(branch_target_o, r.target, "branch_target_o");
        end
    endtask

    task automatic check_bundle(input row_t r);
        check(32'(ex_valid_o), 32'(r.valid), "ex_valid_o");
        check(32'(ex_we_o), 32'(r.valid & r.we), "ex_we_o");
        check(32'(ex_illegal_o), 32'(r.valid & r.illegal), "ex_illegal_o");
        if (!r.valid) begin
            check(32'(ex_aluop_o), 32'(ALUOP_NOP), "bubble ex_aluop_o");
        end else begin
            check(32'(ex_aluop_o), 32'(r.aluop), "ex_aluop_o");
            check(32'(ex_alusel_o), 32'(r.alusel), "ex_alusel_o");
            if (!r.illegal) begin
                check(ex_opa_o, r.opa, "ex_opa_o");
                check(ex_opb_o, r.opb, "ex_opb_o");
                check(ex_link_addr_o, r.link, "ex_link_addr_o");
                if (r.we) begin
                    check(32'(ex_waddr_o), 32'(r.waddr), "ex_waddr_o");
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        row_t r;
        reset_i = 1'b1;
        drive_row('0);
        fill_table();
        table_loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check(32'(ex_valid_o), 32'h0, "reset ex_valid_o");
        check(32'(ex_we_o), 32'h0, "reset ex_we_o");
        check(32'(ex_illegal_o), 32'h0, "reset ex_illegal_o");
        check(32'(ex_aluop_o), 32'(ALUOP_NOP), "reset ex_aluop_o");
        check(32'(ex_alusel_o), 32'(ALUSEL_NOP), "reset ex_alusel_o");
        reset_i = 1'b0;
        for (int i = 0; i < vecs.size(); i++) begin
            cur_row = i;
            r = vecs[i];
            drive_row(r);
            #(CLK_PERIOD / 2 - 1);
            check_branch(r);
            @(posedge clk);
            #1;
            check_bundle(r);
            @(negedge clk);
        end
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog, scaled by the table length
    initial begin
        wait (table_loaded);
        #((vecs.size() * 4 + 20) * CLK_PERIOD);
        $display("timeout: the table loop did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* all.f */
+incdir+test
hw/la_id_pkg.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/operand_bypass.sv
hw/branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
test/tb_id_stage.sv

/* run.sh */
#!/bin/sh
# build and run the id stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_stage -f all.f

./obj_dir/Vtb_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
